/* logic/core_top.sv */
// load the program with run_i low; retire_* mirrors the register write port plus pc
`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter int mem_addr_w = 10
)
(
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic                            run_i,
    input  logic                            load_we_i,
    input  logic [mem_addr_w-1:0]           load_addr_i,
    input  logic [rv_pkg::xlen_c-1:0]       load_data_i,
    output logic                            retire_valid_o,
    output logic [rv_pkg::xlen_c-1:0]       retire_pc_o,
    output logic [rv_pkg::reg_addr_w_c-1:0] retire_rd_o,
    output logic                            retire_we_o,
    output logic [rv_pkg::xlen_c-1:0]       retire_data_o
);
    import rv_pkg::*;

    logic [xlen_c-1:0]       instr;
    logic [xlen_c-1:0]       instr_pc;
    logic                    instr_valid;
    logic                    stall;
    logic                    redirect;
    logic [xlen_c-1:0]       redirect_pc;
    logic [reg_addr_w_c-1:0] rs1_addr;
    logic [reg_addr_w_c-1:0] rs2_addr;
    logic [xlen_c-1:0]       rs1_data;
    logic [xlen_c-1:0]       rs2_data;
    logic                    rd_we;
    logic [reg_addr_w_c-1:0] rd_addr;
    logic [xlen_c-1:0]       rd_data;

    mem_if #(.mem_addr_w(mem_addr_w)) fetch_mem ();
    mem_if #(.mem_addr_w(mem_addr_w)) data_mem ();
    mem_if #(.mem_addr_w(mem_addr_w)) shared_mem ();

    fetch_unit #(.mem_addr_w(mem_addr_w)) fetch_unit (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .run_i(run_i),
        .stall_i(stall),
        .redirect_i(redirect),
        .redirect_pc_i(redirect_pc),
        .mem(fetch_mem),

        .instr_o(instr),
        .instr_pc_o(instr_pc),
        .instr_valid_o(instr_valid)
    );

    exec_unit #(.mem_addr_w(mem_addr_w)) exec_unit (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .instr_i(instr),
        .instr_pc_i(instr_pc),
        .instr_valid_i(instr_valid),

        .rs1_addr_o(rs1_addr),
        .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .rd_we_o(rd_we),
        .rd_addr_o(rd_addr),
        .rd_data_o(rd_data),
        .mem(data_mem),

        .stall_o(stall),
        .redirect_o(redirect),
        .redirect_pc_o(redirect_pc),
        .retire_valid_o(retire_valid_o),
        .retire_pc_o(retire_pc_o)
    );

    reg_file reg_file (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .rs1_addr_i(rs1_addr),
        .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .we_i(rd_we),
        .rd_addr_i(rd_addr),
        .rd_data_i(rd_data)
    );

    mem_arbiter #(.mem_addr_w(mem_addr_w)) mem_arbiter (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .data_port(data_mem),
        .fetch_port(fetch_mem),
        .mem(shared_mem)
    );

    unified_mem #(.mem_addr_w(mem_addr_w)) unified_mem (
        .clk_i(clk_i),
        .port(shared_mem),
        .load_we_i(load_we_i),
        .load_addr_i(load_addr_i),
        .load_data_i(load_data_i)
    );

    assign retire_rd_o   = rd_addr;
    assign retire_we_o   = rd_we;
    assign retire_data_o = rd_data;

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
// single-stage execute; stores rely on data always winning arbitration, loads take two extra cycles
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
    parameter int mem_addr_w = 10
)
(
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic [rv_pkg::xlen_c-1:0]       instr_i,
    input  logic [rv_pkg::xlen_c-1:0]       instr_pc_i,
    input  logic                            instr_valid_i,
    output logic [rv_pkg::reg_addr_w_c-1:0] rs1_addr_o,
    output logic [rv_pkg::reg_addr_w_c-1:0] rs2_addr_o,
    input  logic [rv_pkg::xlen_c-1:0]       rs1_data_i,
    input  logic [rv_pkg::xlen_c-1:0]       rs2_data_i,
    output logic                            rd_we_o,
    output logic [rv_pkg::reg_addr_w_c-1:0] rd_addr_o,
    output logic [rv_pkg::xlen_c-1:0]       rd_data_o,
    mem_if.requester                        mem,
    output logic                            stall_o,
    output logic                            redirect_o,
    output logic [rv_pkg::xlen_c-1:0]       redirect_pc_o,
    output logic                            retire_valid_o,
    output logic [rv_pkg::xlen_c-1:0]       retire_pc_o
);
    import rv_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT} state_t;

    state_t                  state_q;
    decoded_t                dec;
    logic [xlen_c-1:0]       op_b;
    logic [xlen_c-1:0]       alu_res;
    logic [xlen_c-1:0]       pc_plus4;
    logic [reg_addr_w_c-1:0] ld_rd_q;
    logic [xlen_c-1:0]       ld_pc_q;
    logic [mem_addr_w-1:0]   ld_addr_q;
    logic                    issue;
    logic                    take_branch;
    logic                    ld_done;

    function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    function automatic decoded_t decode(input logic [xlen_c-1:0] ins);
        decoded_t d;
        opcode_t  opc;
        d      = '0;
        opc    = opcode_t'(ins[6:0]);
        d.rs1  = ins[19:15];
        d.rs2  = ins[24:20];
        d.imm  = {{20{ins[31]}}, ins[31:20]};
        case (opc)
            OPC_OP: begin
                d.alu_op    = alu_from_funct(ins[14:12], ins[30]);
                d.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                d.alu_op    = alu_from_funct(ins[14:12], 1'b0);
                d.use_imm   = 1'b1;
                d.reg_write = 1'b1;
            end
            OPC_LUI: begin
                d.alu_op    = ALU_PASS_B;
                d.imm       = {ins[31:12], 12'b0};
                d.use_imm   = 1'b1;
                d.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                d.use_imm   = 1'b1;
                d.reg_write = 1'b1;
                d.is_load   = 1'b1;
            end
            OPC_STORE: begin
                d.imm      = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                d.use_imm  = 1'b1;
                d.is_store = 1'b1;
            end
            OPC_BRANCH: begin
                d.imm       = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                d.is_branch = 1'b1;
                d.branch_ne = ins[12];
            end
            OPC_JAL: begin
                d.imm       = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                d.reg_write = 1'b1;
                d.is_jal    = 1'b1;
            end
            default: ;
        endcase
        // rd only reported when the instruction writes
        if (d.reg_write) begin
            d.rd = ins[11:7];
        end
        return d;
    endfunction

    assign dec        = decode(instr_i);
    assign rs1_addr_o = dec.rs1;
    assign rs2_addr_o = dec.rs2;
    assign issue      = instr_valid_i & (state_q == S_IDLE);
    assign op_b       = dec.use_imm ? dec.imm : rs2_data_i;
    assign pc_plus4   = instr_pc_i + 32'd4;

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:    alu_res = rs1_data_i - op_b;
            ALU_AND:    alu_res = rs1_data_i & op_b;
            ALU_OR:     alu_res = rs1_data_i | op_b;
            ALU_XOR:    alu_res = rs1_data_i ^ op_b;
            ALU_SLT:    alu_res = {{(xlen_c-1){1'b0}}, $signed(rs1_data_i) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = rs1_data_i + op_b;
        endcase
    end

    assign take_branch   = dec.is_branch & ((rs1_data_i == rs2_data_i) ^ dec.branch_ne);
    assign redirect_o    = issue & (take_branch | dec.is_jal);
    assign redirect_pc_o = instr_pc_i + dec.imm;

    // store goes out directly, load waits one cycle in S_REQ
    assign mem.req   = (state_q == S_REQ) | (issue & dec.is_store);
    assign mem.we    = (state_q == S_IDLE);
    assign mem.addr  = (state_q == S_REQ) ? ld_addr_q : alu_res[mem_addr_w+1:2];
    assign mem.wdata = rs2_data_i;

    assign ld_done = (state_q == S_WAIT) & mem.rvalid;
    assign stall_o = (issue & dec.is_load) | (state_q == S_REQ) | ((state_q == S_WAIT) & ~mem.rvalid);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE:  if (issue && dec.is_load) state_q <= S_REQ;
                S_REQ:   if (mem.gnt) state_q <= S_WAIT;
                S_WAIT:  if (mem.rvalid) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue && dec.is_load) begin
            ld_rd_q   <= dec.rd;
            ld_pc_q   <= instr_pc_i;
            ld_addr_q <= alu_res[mem_addr_w+1:2];
        end
    end

    // writeback, x0 writes reported with we low
    assign rd_addr_o = ld_done ? ld_rd_q : dec.rd;
    assign rd_data_o = ld_done ? mem.rdata : (dec.is_jal ? pc_plus4 : alu_res);
    assign rd_we_o   = ((issue & dec.reg_write & ~dec.is_load) | ld_done) & (rd_addr_o != '0);

    assign retire_valid_o = (issue & ~dec.is_load & (~dec.is_store | mem.gnt)) | ld_done;
    assign retire_pc_o    = ld_done ? ld_pc_q : instr_pc_i;

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
// one fetch in flight at most; the memory's read register serves as the instruction register
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int mem_addr_w = 10
)
(
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      run_i,
    input  logic                      stall_i,
    input  logic                      redirect_i,
    input  logic [rv_pkg::xlen_c-1:0] redirect_pc_i,
    mem_if.requester                  mem,
    output logic [rv_pkg::xlen_c-1:0] instr_o,
    output logic [rv_pkg::xlen_c-1:0] instr_pc_o,
    output logic                      instr_valid_o
);
    import rv_pkg::*;

    logic [xlen_c-1:0] pc_q;
    logic [xlen_c-1:0] fetch_pc_q;
    logic              drop_q;
    logic              fetch_acc;

    // no new fetch while execute holds a load
    assign mem.req   = run_i & ~stall_i;
    assign mem.we    = 1'b0;
    assign mem.wdata = '0;
    assign mem.addr  = pc_q[mem_addr_w+1:2];

    assign fetch_acc = mem.req & mem.gnt;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q       <= '0;
            fetch_pc_q <= '0;
            drop_q     <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (fetch_acc) begin
                pc_q <= pc_q + 32'd4;
            end
            if (fetch_acc) begin
                fetch_pc_q <= pc_q;
            end
            // the word fetched alongside a redirect is on the wrong path
            drop_q <= redirect_i;
        end
    end

    assign instr_o       = mem.rdata;
    assign instr_pc_o    = fetch_pc_q;
    assign instr_valid_o = mem.rvalid & ~drop_q;

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
// data always beats fetch; one read outstanding at a time, tracked by the owner bit
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
    parameter int mem_addr_w = 10
)
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    mem_if.responder  data_port,
    mem_if.responder  fetch_port,
    mem_if.requester  mem
);

    logic                  data_sel;
    logic                  owner_q;
    logic [mem_addr_w-1:0] addr_sel;

    assign data_sel = data_port.req;

    // same-cycle grants, at most one high
    assign data_port.gnt  = data_sel & mem.gnt;
    assign fetch_port.gnt = ~data_sel & fetch_port.req & mem.gnt;

    assign addr_sel  = data_sel ? data_port.addr : fetch_port.addr;
    assign mem.req   = data_port.req | fetch_port.req;
    assign mem.we    = data_sel ? data_port.we : fetch_port.we;
    assign mem.addr  = addr_sel;
    assign mem.wdata = data_sel ? data_port.wdata : fetch_port.wdata;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            owner_q <= 1'b0;
        end else if (mem.req && mem.gnt && !mem.we) begin
            owner_q <= data_sel;
        end
    end

    // response goes back to whoever issued the read
    assign data_port.rvalid  = mem.rvalid & owner_q;
    assign fetch_port.rvalid = mem.rvalid & ~owner_q;
    assign data_port.rdata   = mem.rdata;
    assign fetch_port.rdata  = mem.rdata;

endmodule

`default_nettype wire

/* logic/mem_if.sv */
// word-addressed memory port; a read's rdata follows its accepted request by exactly one cycle
`timescale 1ns/1ps
`default_nettype none

interface mem_if #(
    parameter int mem_addr_w = 10
);
    import rv_pkg::*;

    logic                  req;
    logic                  we;
    logic [mem_addr_w-1:0] addr;
    logic [xlen_c-1:0]     wdata;
    logic                  gnt;
    logic                  rvalid;
    logic [xlen_c-1:0]     rdata;

    // accepted when req and gnt are both high
    modport requester (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport responder (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

`default_nettype wire

/* logic/reg_file.sv */
// x0 is cleared by reset and never written; reads are combinational
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic [rv_pkg::reg_addr_w_c-1:0] rs1_addr_i,
    input  logic [rv_pkg::reg_addr_w_c-1:0] rs2_addr_i,
    output logic [rv_pkg::xlen_c-1:0]       rs1_data_o,
    output logic [rv_pkg::xlen_c-1:0]       rs2_data_o,
    input  logic                            we_i,
    input  logic [rv_pkg::reg_addr_w_c-1:0] rd_addr_i,
    input  logic [rv_pkg::xlen_c-1:0]       rd_data_i
);
    import rv_pkg::*;

    logic [xlen_c-1:0] regs_q [0:(1<<reg_addr_w_c)-1];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < (1 << reg_addr_w_c); i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && rd_addr_i != '0) begin
            regs_q[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = regs_q[rs1_addr_i];
    assign rs2_data_o = regs_q[rs2_addr_i];

endmodule

`default_nettype wire

/* logic/rv_pkg.sv */
// rv32i subset only: word accesses, no csr, no exceptions; unknown opcodes retire as no-ops
`default_nettype none

package rv_pkg;

    localparam int xlen_c       = 32;
    localparam int reg_addr_w_c = 5;

    // major opcodes of the subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    typedef struct packed {
        alu_op_t                 alu_op;
        logic [reg_addr_w_c-1:0] rs1;
        logic [reg_addr_w_c-1:0] rs2;
        logic [reg_addr_w_c-1:0] rd;
        logic [xlen_c-1:0]       imm;
        logic                    use_imm;
        logic                    reg_write;
        logic                    is_load;
        logic                    is_store;
        logic                    is_branch;
        logic                    is_jal;
        logic                    branch_ne;
    } decoded_t;

endpackage

`default_nettype wire

/* logic/unified_mem.sv */
// no reset; rvalid settles on the first clock edge while requesters are held idle in reset
`timescale 1ns/1ps
`default_nettype none

module unified_mem #(
    parameter int mem_addr_w = 10
)
(
    input  logic                      clk_i,
    mem_if.responder                  port,
    input  logic                      load_we_i,
    input  logic [mem_addr_w-1:0]     load_addr_i,
    input  logic [rv_pkg::xlen_c-1:0] load_data_i
);
    import rv_pkg::*;

    logic [xlen_c-1:0] mem_q [0:(1<<mem_addr_w)-1];
    logic [xlen_c-1:0] rdata_q;
    logic              rvalid_q;
    logic              acc;

    // load port wins, only used before run
    assign port.gnt = ~load_we_i;
    assign acc      = port.req & port.gnt;

    always_ff @(posedge clk_i) begin
        if (load_we_i) begin
            mem_q[load_addr_i] <= load_data_i;
        end else if (acc && port.we) begin
            mem_q[port.addr] <= port.wdata;
        end
        if (acc && !port.we) begin
            rdata_q <= mem_q[port.addr];
        end
        rvalid_q <= acc & ~port.we;
    end

    assign port.rvalid = rvalid_q;
    assign port.rdata  = rdata_q;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build core_tb with Verilator, run it, and decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module core_tb -f vlog.f -o core_tb_sim \
    && ./obj_dir/core_tb_sim | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tests/core_props.sv */
// bound into core_top; watches the arbiter through the mem_if instances, plus the retire port
`timescale 1ns/1ps
`default_nettype none

module core_props (
    input logic       clk_i,
    input logic       arst_n_i,
    input logic       data_req,
    input logic       data_we,
    input logic       data_gnt,
    input logic       data_rvalid,
    input logic       fetch_req,
    input logic       fetch_we,
    input logic       fetch_gnt,
    input logic       fetch_rvalid,
    input logic       retire_we,
    input logic [4:0] retire_rd
);

    // at most one grant per cycle
    assert property (@(posedge clk_i) disable iff (!arst_n_i) !(data_gnt && fetch_gnt))
        else $error("data and fetch were granted in the same cycle");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        data_req && data_gnt && !data_we |=> data_rvalid)
        else $error("granted data read without rvalid one cycle later");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fetch_req && fetch_gnt && !fetch_we |=> fetch_rvalid)
        else $error("granted fetch read without rvalid one cycle later");

    // x0 writes must show up with we low
    assert property (@(posedge clk_i) disable iff (!arst_n_i) retire_we |-> retire_rd != 5'd0)
        else $error("register write reported for x0");

endmodule

bind core_top core_props i_props (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .data_req(data_mem.req),
    .data_we(data_mem.we),
    .data_gnt(data_mem.gnt),
    .data_rvalid(data_mem.rvalid),
    .fetch_req(fetch_mem.req),
    .fetch_we(fetch_mem.we),
    .fetch_gnt(fetch_mem.gnt),
    .fetch_rvalid(fetch_mem.rvalid),
    .retire_we(retire_we_o),
    .retire_rd(retire_rd_o)
);

`default_nettype wire

/* tests/core_tb.sv */
// program must end in a self-loop; only forward branches, so retire order follows table order
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam int mem_addr_w_c       = 10;
    localparam int reset_cycles_c     = 16;
    localparam int cycles_per_entry_c = 40;
    localparam int idle_cycles_c      = 4;

    logic                    clk_i;
    logic                    arst_n_i;
    logic                    run_i;
    logic                    load_we_i;
    logic [mem_addr_w_c-1:0] load_addr_i;
    logic [31:0]             load_data_i;
    logic                    retire_valid_o;
    logic [31:0]             retire_pc_o;
    logic [4:0]              retire_rd_o;
    logic                    retire_we_o;
    logic [31:0]             retire_data_o;

    // one row per program word at pc 4 * index
    logic [31:0] prog_q[$];
    logic [4:0]  exp_rd_q[$];
    logic        exp_we_q[$];
    logic [31:0] exp_data_q[$];
    logic        exp_ret_q[$];

    logic [31:0] xr [0:31];
    logic [31:0] lcg_state;
    int          error_cnt;
    int          check_cnt;

    core_top #(.mem_addr_w(mem_addr_w_c)) i_dut (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .run_i(run_i),
        .load_we_i(load_we_i),
        .load_addr_i(load_addr_i),
        .load_data_i(load_data_i),
        .retire_valid_o(retire_valid_o),
        .retire_pc_o(retire_pc_o),
        .retire_rd_o(retire_rd_o),
        .retire_we_o(retire_we_o),
        .retire_data_o(retire_data_o)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic sub, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic add_entry(input logic [31:0] ins, input logic [4:0] rd,
                             input logic [31:0] data, input logic ret);
        prog_q.push_back(ins);
        exp_rd_q.push_back(rd);
        exp_we_q.push_back(ret && rd != 5'd0);
        exp_data_q.push_back(data);
        exp_ret_q.push_back(ret);
        if (ret && rd != 5'd0) begin
            xr[rd] = data;
        end
    endtask

    task automatic build_program();
        logic [11:0] imm;
        logic [31:0] pc;
        for (int r = 0; r < 32; r++) begin
            xr[r] = '0;
        end
        lcg_state = 32'd49;
        lcg_state = lcg_next(lcg_state);
        imm = lcg_state[27:16];
        add_entry(enc_i(imm, 5'd0, 3'b000, 5'd1, 7'b0010011), 5'd1, sext12(imm), 1'b1);
        lcg_state = lcg_next(lcg_state);
        imm = lcg_state[27:16];
        add_entry(enc_i(imm, 5'd0, 3'b000, 5'd2, 7'b0010011), 5'd2, sext12(imm), 1'b1);
        add_entry(enc_r(1'b0, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, xr[1] + xr[2], 1'b1);
        add_entry(enc_r(1'b1, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, xr[1] - xr[2], 1'b1);
        add_entry(enc_r(1'b0, 5'd2, 5'd1, 3'b111, 5'd5), 5'd5, xr[1] & xr[2], 1'b1);
        add_entry(enc_r(1'b0, 5'd2, 5'd1, 3'b110, 5'd6), 5'd6, xr[1] | xr[2], 1'b1);
        add_entry(enc_r(1'b0, 5'd2, 5'd1, 3'b100, 5'd7), 5'd7, xr[1] ^ xr[2], 1'b1);
        add_entry(enc_r(1'b0, 5'd2, 5'd1, 3'b010, 5'd8), 5'd8,
                  ($signed(xr[1]) < $signed(xr[2])) ? 32'd1 : 32'd0, 1'b1);
        add_entry({20'h12345, 5'd9, 7'b0110111}, 5'd9, 32'h12345000, 1'b1);
        // write to x0 retires with we low
        lcg_state = lcg_next(lcg_state);
        imm = lcg_state[27:16];
        add_entry(enc_i(imm, 5'd1, 3'b000, 5'd0, 7'b0010011), 5'd0, 32'd0, 1'b1);
        lcg_state = lcg_next(lcg_state);
        imm = lcg_state[27:16];
        add_entry(enc_i(imm, 5'd9, 3'b000, 5'd10, 7'b0010011), 5'd10,
                  xr[9] + sext12(imm), 1'b1);
        add_entry(enc_s(12'h200, 5'd3, 5'd0), 5'd0, 32'd0, 1'b1);
        add_entry(enc_i(12'h200, 5'd0, 3'b010, 5'd11, 7'b0000011), 5'd11, xr[3], 1'b1);
        // taken beq skips the next word and bne falls through
        add_entry(enc_b(13'd8, 5'd3, 5'd11, 3'b000), 5'd0, 32'd0, 1'b1);
        add_entry(enc_i(12'd1, 5'd0, 3'b000, 5'd12, 7'b0010011), 5'd12, 32'd1, 1'b0);
        add_entry(enc_b(13'd8, 5'd1, 5'd1, 3'b001), 5'd0, 32'd0, 1'b1);
        pc = 32'(prog_q.size()) * 32'd4;
        add_entry(enc_j(21'd8, 5'd13), 5'd13, pc + 32'd4, 1'b1);
        add_entry(enc_i(12'd2, 5'd0, 3'b000, 5'd14, 7'b0010011), 5'd14, 32'd2, 1'b0);
        add_entry(enc_i(12'd0, 5'd13, 3'b000, 5'd15, 7'b0010011), 5'd15, xr[13], 1'b1);
        add_entry(enc_j(21'd0, 5'd0), 5'd0, 32'd0, 1'b1);
    endtask

    task automatic wait_retire();
        do begin
            @(negedge clk_i);
        end while (!retire_valid_o);
    endtask

    initial begin : watchdog
        #1;
        repeat (reset_cycles_c + idle_cycles_c + (cycles_per_entry_c + 2) * prog_q.size())
            @(posedge clk_i);
        $display("timeout: the core did not retire the expected sequence in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        clk_i       = 1'b0;
        arst_n_i    = 1'b0;
        run_i       = 1'b0;
        load_we_i   = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        error_cnt   = 0;
        check_cnt   = 0;
        build_program();
        repeat (reset_cycles_c) @(posedge clk_i);
        arst_n_i <= 1'b1;
        // core has to stay idle while the program goes in
        for (int i = 0; i < prog_q.size(); i++) begin
            @(posedge clk_i);
            load_we_i   <= 1'b1;
            load_addr_i <= mem_addr_w_c'(i);
            load_data_i <= prog_q[i];
            @(negedge clk_i);
            check("retire_valid_o", 32'(retire_valid_o), 32'd0);
        end
        @(posedge clk_i);
        load_we_i <= 1'b0;
        // with the memory free again the core still waits for run_i
        repeat (idle_cycles_c) begin
            @(negedge clk_i);
            check("retire_valid_o", 32'(retire_valid_o), 32'd0);
        end
        @(posedge clk_i);
        run_i <= 1'b1;
        for (int i = 0; i < prog_q.size(); i++) begin
            if (exp_ret_q[i]) begin
                wait_retire();
                check("retire_pc_o", retire_pc_o, 32'(i) * 32'd4);
                check("retire_we_o", 32'(retire_we_o), 32'(exp_we_q[i]));
                if (exp_we_q[i]) begin
                    check("retire_rd_o", 32'(retire_rd_o), 32'(exp_rd_q[i]));
                    check("retire_data_o", retire_data_o, exp_data_q[i]);
                end
            end
        end
        $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
logic/rv_pkg.sv
logic/mem_if.sv
logic/fetch_unit.sv
logic/exec_unit.sv
logic/reg_file.sv
logic/mem_arbiter.sv
logic/unified_mem.sv
logic/core_top.sv
tests/core_props.sv
tests/core_tb.sv
